// ==== Makefile ====
# Verilator build and run for the bouncing square display

VERILATOR ?= verilator
TOP       ?= bounce_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== source/bounce_cfg.svh ====
// =========================================================================
// bounce display configuration
// raster geometry, framebuffer size and drawing colours
// =========================================================================
`ifndef BOUNCE_CFG_SVH
`define BOUNCE_CFG_SVH

// raster, in pixels and lines
`define BOUNCE_H_ACTIVE     64
`define BOUNCE_H_TOTAL      80
`define BOUNCE_H_SYNC_START 68
`define BOUNCE_H_SYNC_END   72
`define BOUNCE_V_ACTIVE     36
`define BOUNCE_V_TOTAL      40
`define BOUNCE_V_SYNC_START 37
`define BOUNCE_V_SYNC_END   38

// framebuffer geometry and upscale
`define BOUNCE_FB_WIDTH     32
`define BOUNCE_FB_HEIGHT    18
`define BOUNCE_FB_SCALE     2

// square edge and colours
`define BOUNCE_SQ_SIZE      8
`define BOUNCE_SQ_CIDX      4'hB
`define BOUNCE_BG_CIDX      4'h0

`endif

// ==== source/bounce_pkg.sv ====
// =========================================================================
// bounce display types
// coordinates, colour indices, memory addresses and the draw FSM states
// =========================================================================
`default_nettype none

package bounce_pkg;

    // screen or framebuffer coordinate
    typedef logic signed [15:0] coord_t;

    // colour index, palette lookup happens downstream
    typedef logic [3:0] cidx_t;

    // framebuffer word address, 576 words
    typedef logic [9:0] fb_addr_t;

    // animator draw sequencing
    typedef enum logic [1:0] {
        IDLE,
        INIT,
        DRAW,
        DONE
    } draw_state_t;

endpackage

`default_nettype wire

// ==== source/bounce_top.sv ====
// =========================================================================
// bouncing square display top level
// timing, animation, drawing and framebuffer on a single clock
// =========================================================================
`default_nettype none
`timescale 1ns/100ps

module bounce_top import bounce_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic reset,
    output cidx_t     pixel,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame
);

    coord_t sx, sy;     // screen position
    logic   hsync_raw;
    logic   vsync_raw;
    logic   de_raw;
    logic   draw_start;
    logic   draw_done;
    logic   fb_wready;
    coord_t rx0, ry0, rx1, ry1;  // square corners

    draw_bus_if draw_bus ();

    display_timing timing_i (
        .clk_100m,
        .reset,
        .sx,
        .sy,
        .hsync (hsync_raw),
        .vsync (vsync_raw),
        .de    (de_raw),
        .frame,
        .line  ()
    );

    square_animator anim_i (
        .clk_100m,
        .reset,
        .frame,
        .wready (fb_wready),
        .done   (draw_done),
        .start  (draw_start),
        .x0     (rx0),
        .y0     (ry0),
        .x1     (rx1),
        .y1     (ry1)
    );

    rect_fill_drawer drawer_i (
        .clk_100m,
        .reset,
        .start (draw_start),
        .x0    (rx0),
        .y0    (ry0),
        .x1    (rx1),
        .y1    (ry1),
        .done  (draw_done),
        .bus   (draw_bus.drawer)
    );

    framebuffer_db fb_i (
        .clk_100m,
        .reset,
        .frame,
        .de     (de_raw),
        .sx,
        .sy,
        .wready (fb_wready),
        .pixel,
        .bus    (draw_bus.memory)
    );

    // framebuffer read takes a cycle, delay sync and enable to match
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
            de    <= de_raw;
        end
    end

endmodule

`default_nettype wire

// ==== source/display_timing.sv ====
// =========================================================================
// display timing for the 64x36 raster, 80x40 total
// screen position, syncs, data enable and frame/line strobes
// =========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module display_timing import bounce_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic reset,
    output coord_t    sx,
    output coord_t    sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame,
    output logic      line
);

    localparam coord_t H_ACTIVE     = coord_t'(`BOUNCE_H_ACTIVE);
    localparam coord_t H_SYNC_START = coord_t'(`BOUNCE_H_SYNC_START);
    localparam coord_t H_SYNC_END   = coord_t'(`BOUNCE_H_SYNC_END);
    localparam coord_t H_LAST       = coord_t'(`BOUNCE_H_TOTAL - 1);
    localparam coord_t V_ACTIVE     = coord_t'(`BOUNCE_V_ACTIVE);
    localparam coord_t V_SYNC_START = coord_t'(`BOUNCE_V_SYNC_START);
    localparam coord_t V_SYNC_END   = coord_t'(`BOUNCE_V_SYNC_END);
    localparam coord_t V_LAST       = coord_t'(`BOUNCE_V_TOTAL - 1);

    coord_t h;  // raster column counter
    coord_t v;  // raster line counter

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            h <= '0;
            v <= '0;
        end else if (h == H_LAST) begin
            h <= '0;
            v <= (v == V_LAST) ? '0 : v + 16'sd1;
        end else begin
            h <= h + 16'sd1;
        end
    end

    // outputs registered together so strobes line up with sx/sy
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= h;
            sy    <= v;
            hsync <= (h >= H_SYNC_START) && (h < H_SYNC_END);  // active high
            vsync <= (v >= V_SYNC_START) && (v < V_SYNC_END);
            de    <= (h < H_ACTIVE) && (v < V_ACTIVE);
            frame <= (h == '0) && (v == '0);  // top left corner
            line  <= (h == '0);
        end
    end

endmodule

`default_nettype wire

// ==== source/draw_bus_if.sv ====
// =========================================================================
// draw bus
// pixel writes from the shape drawer into the framebuffer
// =========================================================================
`default_nettype none
`timescale 1ns/100ps

interface draw_bus_if import bounce_pkg::*; ();

    logic   we;    // one pixel written per high cycle
    coord_t x;     // framebuffer column
    coord_t y;     // framebuffer row
    cidx_t  cidx;  // colour to write
    logic   busy;  // memory clearing, drawer holds position

    modport drawer (
        output we, x, y, cidx,
        input  busy
    );

    modport memory (
        input  we, x, y, cidx,
        output busy
    );

endinterface

`default_nettype wire

// ==== source/framebuffer_db.sv ====
// =========================================================================
// double-buffered colour-index framebuffer
// clears the back bank, takes draw writes, swaps at frame, scaled readout
// =========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module framebuffer_db import bounce_pkg::*; (
    input  wire logic   clk_100m,
    input  wire logic   reset,
    input  wire logic   frame,
    input  wire logic   de,
    input  wire coord_t sx,
    input  wire coord_t sy,
    output logic        wready,
    output cidx_t       pixel,
    draw_bus_if.memory  bus
);

    localparam int       DEPTH = `BOUNCE_FB_WIDTH * `BOUNCE_FB_HEIGHT;
    localparam fb_addr_t LAST  = fb_addr_t'(DEPTH - 1);

    cidx_t    bank0 [DEPTH];
    cidx_t    bank1 [DEPTH];
    logic     front_sel;  // 1 shows bank1, writes go to bank0
    logic     front_ok;   // a drawn bank has been swapped in
    logic     boot;       // first cycle out of reset
    logic     clearing;
    logic     drawn;      // back bank holds a fresh image
    fb_addr_t clr_addr;
    logic     swap;
    logic     wr_en;
    fb_addr_t wr_addr;
    cidx_t    wr_data;
    fb_addr_t rd_addr;

    assign swap     = frame && drawn;
    assign bus.busy = clearing;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            boot      <= 1'b1;
            clearing  <= 1'b0;
            clr_addr  <= '0;
            front_sel <= 1'b0;
            front_ok  <= 1'b0;
            drawn     <= 1'b0;
            wready    <= 1'b0;
        end else begin
            boot <= 1'b0;
            if (boot || swap) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end else if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == LAST) begin
                    clearing <= 1'b0;
                    wready   <= 1'b1;  // back bank blank, ready to draw
                end
            end
            if (swap) begin
                front_sel <= ~front_sel;
                front_ok  <= 1'b1;
                drawn     <= 1'b0;
                wready    <= 1'b0;
            end else if (bus.we) begin
                drawn  <= 1'b1;
                wready <= 1'b0;
            end
        end
    end

    // clear and draw never overlap, busy keeps the drawer off the port
    assign wr_en   = clearing || bus.we;
    assign wr_addr = clearing ? clr_addr
                              : fb_addr_t'(bus.y * `BOUNCE_FB_WIDTH + bus.x);
    assign wr_data = clearing ? `BOUNCE_BG_CIDX : bus.cidx;

    // each fb pixel covers a SCALE x SCALE block on screen
    assign rd_addr = fb_addr_t'((sy / `BOUNCE_FB_SCALE) * `BOUNCE_FB_WIDTH
                                + sx / `BOUNCE_FB_SCALE);

    always_ff @(posedge clk_100m) begin
        if (wr_en) begin
            if (front_sel) begin
                bank0[wr_addr] <= wr_data;
            end else begin
                bank1[wr_addr] <= wr_data;
            end
        end
        if (de && front_ok) begin
            pixel <= front_sel ? bank1[rd_addr] : bank0[rd_addr];
        end else begin
            pixel <= `BOUNCE_BG_CIDX;  // blanking or nothing shown yet
        end
    end

endmodule

`default_nettype wire

// ==== source/rect_fill_drawer.sv ====
// =========================================================================
// filled rectangle drawer
// row-major walk over [x0,x1) x [y0,y1), one pixel per non-busy cycle
// =========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module rect_fill_drawer import bounce_pkg::*; (
    input  wire logic   clk_100m,
    input  wire logic   reset,
    input  wire logic   start,
    input  wire coord_t x0,
    input  wire coord_t y0,
    input  wire coord_t x1,
    input  wire coord_t y1,
    output logic        done,
    draw_bus_if.drawer  bus
);

    coord_t cx, cy;       // current pixel
    coord_t left;         // column to return to at row end
    coord_t right_last;   // last column, x1-1
    coord_t bottom_last;  // last row, y1-1
    logic   active;
    logic   last;

    assign last     = (cx == right_last) && (cy == bottom_last);
    assign bus.we   = active && !bus.busy;  // hold while memory clears
    assign bus.x    = cx;
    assign bus.y    = cy;
    assign bus.cidx = `BOUNCE_SQ_CIDX;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= bus.we && last;  // one cycle after final write
            if (start) begin
                active <= 1'b1;
            end else if (bus.we && last) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start) begin
            cx          <= x0;
            cy          <= y0;
            left        <= x0;
            right_last  <= x1 - 16'sd1;
            bottom_last <= y1 - 16'sd1;
        end else if (bus.we) begin
            if (cx == right_last) begin
                cx <= left;  // next row
                cy <= cy + 16'sd1;
            end else begin
                cx <= cx + 16'sd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/square_animator.sv ====
// =========================================================================
// square animator
// bounces the square once per frame and launches one draw per frame
// =========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module square_animator import bounce_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic reset,
    input  wire logic frame,
    input  wire logic wready,
    input  wire logic done,
    output logic      start,
    output coord_t    x0,
    output coord_t    y0,
    output coord_t    x1,
    output coord_t    y1
);

    localparam int     X_LIMIT = `BOUNCE_FB_WIDTH - (`BOUNCE_SQ_SIZE + 1);
    localparam int     Y_LIMIT = `BOUNCE_FB_HEIGHT - (`BOUNCE_SQ_SIZE + 1);
    localparam coord_t SQ_SIZE = coord_t'(`BOUNCE_SQ_SIZE);

    coord_t      qx, qy;    // top left of square
    logic        qdx, qdy;  // 1 moves left/up
    draw_state_t state;

    // one axis step, returns {direction, position}
    function automatic logic [16:0] step(input coord_t pos, input logic neg,
                                         input int limit);
        logic [16:0] nxt;
        if (pos >= limit) begin
            nxt = {1'b1, pos - 16'sd1};  // far edge, turn back
        end else if (pos < 1) begin
            nxt = {1'b0, pos + 16'sd1};  // near edge
        end else begin
            nxt = {neg, neg ? pos - 16'sd1 : pos + 16'sd1};
        end
        return nxt;
    endfunction

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            qx  <= '0;
            qy  <= '0;
            qdx <= 1'b0;
            qdy <= 1'b0;
        end else if (frame) begin
            {qdx, qx} <= step(qx, qdx, X_LIMIT);
            {qdy, qy} <= step(qy, qdy, Y_LIMIT);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state <= IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;  // single cycle pulse
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    if (wready) begin
                        start <= 1'b1;
                        state <= DRAW;
                    end
                end
                DRAW: if (done) state <= DONE;
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // corners latched together with start
    always_ff @(posedge clk_100m) begin
        if (state == INIT && wready) begin
            x0 <= qx;
            y0 <= qy;
            x1 <= qx + SQ_SIZE;
            y1 <= qy + SQ_SIZE;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/bounce_chk.sv ====
// ==========================================================================
// bound assertions on the frame strobe and the draw bus
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module bounce_chk import bounce_pkg::*; (
    input wire logic   clk_100m,
    input wire logic   reset,
    input wire logic   frame,
    input wire logic   we,
    input wire logic   busy,
    input wire coord_t x,
    input wire coord_t y,
    input wire logic   done
);

    localparam coord_t FB_W = coord_t'(`BOUNCE_FB_WIDTH);
    localparam coord_t FB_H = coord_t'(`BOUNCE_FB_HEIGHT);

    frame_single_a: assert property (@(posedge clk_100m) disable iff (reset)
        frame |=> !frame)
        else $error("frame strobe high in two consecutive cycles");

    we_not_busy_a: assert property (@(posedge clk_100m) disable iff (reset)
        !(we && busy))
        else $error("write while framebuffer busy");

    write_in_range_a: assert property (@(posedge clk_100m) disable iff (reset)
        we |-> (x >= 16'sd0 && x < FB_W && y >= 16'sd0 && y < FB_H))
        else $error("write outside framebuffer");

    done_after_write_a: assert property (@(posedge clk_100m) disable iff (reset)
        done |-> $past(we))
        else $error("done without a write in the previous cycle");

endmodule

bind display_timing bounce_chk timing_chk_i (
    .clk_100m (clk_100m),
    .reset    (reset),
    .frame    (frame),
    .we       (1'b0),
    .busy     (1'b0),
    .x        (16'sd0),
    .y        (16'sd0),
    .done     (1'b0)
);

bind rect_fill_drawer bounce_chk drawer_chk_i (
    .clk_100m (clk_100m),
    .reset    (reset),
    .frame    (1'b0),
    .we       (bus.we),
    .busy     (bus.busy),
    .x        (bus.x),
    .y        (bus.y),
    .done     (done)
);

`default_nettype wire

// ==== testbench/bounce_tb.sv ====
// ==========================================================================
// bouncing square display testbench
// random mid-run resets, bounce and raster model, per-pixel output checks
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps
`include "bounce_cfg.svh"

module bounce_tb import bounce_pkg::*; ();

    localparam int H_TOTAL        = `BOUNCE_H_TOTAL;
    localparam int V_TOTAL        = `BOUNCE_V_TOTAL;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int SQ_SIZE        = `BOUNCE_SQ_SIZE;
    localparam int X_LIMIT        = `BOUNCE_FB_WIDTH - `BOUNCE_SQ_SIZE - 1;
    localparam int Y_LIMIT        = `BOUNCE_FB_HEIGHT - `BOUNCE_SQ_SIZE - 1;
    localparam int CHECKED_TARGET = 10;
    localparam int CYCLE_LIMIT    = 12 * FRAME_CYCLES + 1000;  // per reset segment

    logic  clk_100m = 1'b0;
    logic  reset = 1'b1;
    cidx_t pixel;
    logic  hsync;
    logic  vsync;
    logic  de;
    logic  frame;

    logic [15:0] lfsr_state = 16'd28916;
    int mx, my;              // model square position
    bit mbx, mby;            // 1 moves left/up
    int shown_x, shown_y;    // square visible in the current frame
    bit shown_valid;
    int cx, cy;              // screen position of the aligned outputs
    bit tracking;            // a strobe has been seen since reset
    int gap;                 // cycles since last strobe
    int strobes;
    int checked_frames = 0;
    int error_count = 0;
    int cycle_count = 0;

    bounce_top dut_i (
        .clk_100m,
        .reset,
        .pixel,
        .hsync,
        .vsync,
        .de,
        .frame
    );

    always #5 clk_100m = ~clk_100m;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // taps 16,14,13,11
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one bounce step on one axis
    task automatic bounce_axis(inout int pos, inout bit back, input int limit);
        if (pos >= limit) begin
            back = 1'b1;  // far edge
            pos = pos - 1;
        end else if (pos < 1) begin
            back = 1'b0;
            pos = pos + 1;
        end else begin
            pos = back ? pos - 1 : pos + 1;
        end
    endtask

    task automatic restart_model();
        mx = 0;
        my = 0;
        mbx = 1'b0;
        mby = 1'b0;
        shown_valid = 1'b0;
        tracking = 1'b0;
        gap = 0;
        strobes = 0;
        checked_frames = 0;
    endtask

    task automatic verify_outputs();
        logic  exp_de;
        logic  exp_hs;
        logic  exp_vs;
        cidx_t exp_pix;
        int    fx;
        int    fy;
        exp_de = (cx < `BOUNCE_H_ACTIVE) && (cy < `BOUNCE_V_ACTIVE);
        exp_hs = (cx >= `BOUNCE_H_SYNC_START) && (cx < `BOUNCE_H_SYNC_END);
        exp_vs = (cy >= `BOUNCE_V_SYNC_START) && (cy < `BOUNCE_V_SYNC_END);
        fx = cx / `BOUNCE_FB_SCALE;
        fy = cy / `BOUNCE_FB_SCALE;
        exp_pix = `BOUNCE_BG_CIDX;
        if (exp_de && shown_valid && fx >= shown_x && fx < shown_x + SQ_SIZE
            && fy >= shown_y && fy < shown_y + SQ_SIZE) begin
            exp_pix = `BOUNCE_SQ_CIDX;
        end
        expect_equal("de", 32'(de), 32'(exp_de));
        expect_equal("hsync", 32'(hsync), 32'(exp_hs));
        expect_equal("vsync", 32'(vsync), 32'(exp_vs));
        expect_equal("pixel", 32'(pixel), 32'(exp_pix));
    endtask

    // image drawn at the previous strobe becomes the front one
    task automatic take_frame_strobe();
        if (tracking) begin
            expect_equal("frame_period", 32'(gap), 32'(FRAME_CYCLES));
            checked_frames++;
        end
        tracking = 1'b1;
        gap = 0;
        strobes++;
        shown_valid = (strobes >= 2);
        shown_x = mx;
        shown_y = my;
        bounce_axis(mx, mbx, X_LIMIT);
        bounce_axis(my, mby, Y_LIMIT);
        cx = 0;
        cy = 0;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk_100m) begin
        if (reset) begin
            restart_model();
        end else begin
            gap = gap + 1;
            if (tracking) begin
                verify_outputs();
            end
            if (frame) begin
                take_frame_strobe();
            end else if (tracking) begin
                cx = cx + 1;
                if (cx == H_TOTAL) begin
                    cx = 0;
                    cy = (cy + 1 == V_TOTAL) ? 0 : cy + 1;
                end
            end
        end
    end

    // watchdog restarts with every reset
    always @(posedge clk_100m) begin
        if (reset) begin
            cycle_count = 0;
        end else begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("timeout: no result within %0d cycles of reset", CYCLE_LIMIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "simulation timeout");
            end
        end
    end

    initial begin
        int run_len;
        repeat (10) @(posedge clk_100m);
        reset <= 1'b0;
        for (int r = 0; r < 2; r++) begin
            take_bits(2, run_len);
            run_len = run_len + 2;  // 2 to 5 full frames
            while (strobes < run_len + 1) @(posedge clk_100m);
            reset <= 1'b1;
            repeat (10) @(posedge clk_100m);
            reset <= 1'b0;
        end
        // blank frame, then ten square frames reaching past the y reversal
        while (checked_frames < CHECKED_TARGET + 1) @(posedge clk_100m);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/bounce_pkg.sv
source/draw_bus_if.sv
source/display_timing.sv
source/square_animator.sv
source/rect_fill_drawer.sv
source/framebuffer_db.sv
source/bounce_top.sv
testbench/bounce_chk.sv
testbench/bounce_tb.sv
